//--- bench/botPermuterTb.sv
`timescale 1ns/1ns
`include "botPermuter_defines.svh"

module botPermuterTb import botPermuterPkg::*; ();
    logic clk;
    logic rst;
    botT bot;
    permMaskT validBotPermutes;
    logic batchDone;
    logic readyForNextBatch;
    botT permutedBot;
    logic permutedBotValid;
    logic batchFinished;
    logic requestSlowDown;

    logic [15:0] lfsrState;
    logic slowDownRandom;
    int inputCycles;
    int cycleCount;
    int mismatchCount;
    int failCount;
    int batchOutputs;
    batchSizeT outCount;
    botT expBots[$];
    batchSizeT expCounts[$];

    botPermuterWithMultiFifo i_botPermuterWithMultiFifo (
        .clk(clk),
        .rst(rst),
        .bot(bot),
        .validBotPermutes(validBotPermutes),
        .batchDone(batchDone),
        .readyForNextBatch(readyForNextBatch),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchFinished(batchFinished),
        .requestSlowDown(requestSlowDown)
    );

    always #2 clk = ~clk;

    // 16-bit Galois LFSR stepped once per bit taken
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < count; k++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic botT randBot();
        botT r;
        for (int w = 0; w < 4; w++) begin
            r[w*32 +: 32] = takeBits(32);
        end
        return r;
    endfunction

    // Mask bit 5 is ABC, bit 0 is CBA
    function automatic string orderName(input int maskBit);
        case (maskBit)
            5: return "ABC";
            4: return "ACB";
            3: return "BAC";
            2: return "BCA";
            1: return "CAB";
            default: return "CBA";
        endcase
    endfunction

    // Variable named k-th moves to position 4+k; A, B, C sit at 4, 5, 6
    function automatic botT permuteRef(input botT src, input int maskBit);
        string name;
        int j;
        int pos;
        botT res;
        name = orderName(maskBit);
        for (int i = 0; i < `BOT_WIDTH; i++) begin
            j = i % 16;
            for (int k = 0; k < 3; k++) begin
                pos = name[k] - "A" + 4;
                j = j + (((i >> (4 + k)) & 1) << pos);
            end
            res[i] = src[j];
        end
        return res;
    endfunction

    task automatic checkBot(input botT got, input botT expected);
        if (got !== expected) begin
            mismatchCount++;
            $display("mismatch at %0t: permutedBot %h, expected %h", $time, got, expected);
        end
    endtask

    task automatic checkBatch(input batchSizeT seen, input batchSizeT expected);
        if (seen !== expected) begin
            mismatchCount++;
            $display("mismatch at %0t: batch closed after %0d outputs, expected %0d",
                     $time, seen, expected);
        end
    endtask

    // Expected outputs in mask order, and one count per batch
    task automatic modelInput(input botT b, input permMaskT m, input logic done);
        for (int k = `PERM_COUNT - 1; k >= 0; k--) begin
            if (m[k]) begin
                expBots.push_back(permuteRef(b, k));
                batchOutputs++;
            end
        end
        if (done) begin
            expCounts.push_back(batchSizeT'(batchOutputs));
            batchOutputs = 0;
        end
        if (m != '0 || done) begin
            inputCycles++;
        end
    endtask

    task automatic driveCycle(input botT b, input permMaskT m, input logic done);
        bot = b;
        validBotPermutes = m;
        batchDone = done;
        requestSlowDown = slowDownRandom ? (takeBits(2) == 2'b00) : 1'b0;
        modelInput(b, m, done);
        @(posedge clk);
        #1;
    endtask

    task automatic startBatch();
        while (!readyForNextBatch) begin
            driveCycle('0, '0, 1'b0);
        end
    endtask

    // Outputs first, so a pulse with the last word counts that word
    always @(negedge clk) begin
        if (!rst) begin
            if (permutedBotValid) begin
                if (expBots.size() == 0) begin
                    failCount++;
                    $display("unexpected output at %0t with nothing expected", $time);
                end else begin
                    checkBot(permutedBot, expBots.pop_front());
                end
                outCount++;
            end
            if (batchFinished) begin
                if (expCounts.size() == 0) begin
                    failCount++;
                    $display("batchFinished at %0t with no batch outstanding", $time);
                end else begin
                    checkBatch(outCount, expCounts.pop_front());
                end
                outCount = '0;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > 40 * (inputCycles + 100)) begin
            $display("timeout after %0d cycles with %0d outputs still expected",
                     cycleCount, expBots.size());
            $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int len;
        permMaskT mask;
        botT word;
        clk = 1'b0;
        rst = 1'b1;
        bot = '0;
        validBotPermutes = '0;
        batchDone = 1'b0;
        requestSlowDown = 1'b0;
        lfsrState = 16'd69;
        slowDownRandom = 1'b0;
        inputCycles = 0;
        cycleCount = 0;
        mismatchCount = 0;
        failCount = 0;
        batchOutputs = 0;
        outCount = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Quiet after reset; the monitor flags any output here
        repeat (4) begin
            if (readyForNextBatch !== 1'b1) begin
                failCount++;
                $display("readyForNextBatch not high after reset at %0t", $time);
            end
            driveCycle('0, '0, 1'b0);
        end

        // Identity ordering alone
        word = randBot();
        startBatch();
        driveCycle(word, 6'b100000, 1'b1);

        // All six orderings of one word
        startBatch();
        driveCycle(randBot(), 6'b111111, 1'b1);

        // Zero masks mixed in and batches ending on a dropped and on a stored word
        startBatch();
        driveCycle(randBot(), 6'b010010, 1'b0);
        driveCycle(randBot(), '0, 1'b0);
        driveCycle(randBot(), 6'b000001, 1'b0);
        driveCycle(randBot(), '0, 1'b1);
        startBatch();
        driveCycle(randBot(), '0, 1'b0);
        driveCycle(randBot(), 6'b101000, 1'b1);

        // Empty batches back to back
        startBatch();
        driveCycle(randBot(), '0, 1'b1);
        startBatch();
        driveCycle('0, '0, 1'b1);

        slowDownRandom = 1'b1;
        repeat (200) begin
            startBatch();
            len = int'(takeBits(4)) % 9;
            if (len == 0) begin
                driveCycle(randBot(), '0, 1'b1);
            end else begin
                for (int n = 0; n < len; n++) begin
                    mask = permMaskT'(takeBits(6));
                    if (takeBits(2) == 2'b00) begin
                        mask = '0;
                    end
                    driveCycle(randBot(), mask, n == len - 1);
                end
            end
        end

        while (expBots.size() != 0 || expCounts.size() != 0) begin
            driveCycle('0, '0, 1'b0);
        end
        repeat (20) driveCycle('0, '0, 1'b0);

        $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+source
source/botPermuterPkg.sv
source/syncFifo.sv
source/botPermuter.sv
source/batchBotBuffer.sv
source/botPermuterWithFifo.sv
source/botPermuterWithMultiFifo.sv
bench/botPermuterTb.sv

//--- source/batchBotBuffer.sv
`timescale 1ns/1ns
`include "botPermuter_defines.svh"

module batchBotBuffer import botPermuterPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  botT       botIn,
    input  permMaskT  validBotPermutesIn,
    output logic      readyForNewBatch,
    input  logic      endBatch,
    output batchSizeT batchSize,
    input  logic      read,
    output botT       botOut,
    output permMaskT  validBotPermutesOut
);
    localparam int bufferDepth = 1 << `BATCH_DEPTH_LOG2;
    localparam int wordWidth = `BOT_WIDTH + `PERM_COUNT;

    logic [wordWidth-1:0] mem [bufferDepth];
    logic [`BATCH_DEPTH_LOG2-1:0] writeAddr;
    logic [`BATCH_DEPTH_LOG2-1:0] readAddr;
    logic [`BATCH_DEPTH_LOG2-1:0] usedWords;
    batchSizeT batchSizeReg;
    logic write;
    logic [wordWidth-1:0] readStage;
    logic [wordWidth-1:0] outStage;

    // Zero-mask words carry nothing worth storing
    assign write = |validBotPermutesIn;

    // Includes the word written in this cycle
    assign batchSize = batchSizeReg + batchSizeT'(write);

    assign usedWords = writeAddr - readAddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            writeAddr <= '0;
            readAddr <= '0;
            batchSizeReg <= '0;
            readyForNewBatch <= 1'b1;
        end else begin
            if (write) begin
                writeAddr <= writeAddr + 1'b1;
            end
            if (read) begin
                readAddr <= readAddr + 1'b1;
            end
            batchSizeReg <= endBatch ? '0 : batchSize;
            readyForNewBatch <= (bufferDepth - int'(usedWords)) >= `READY_FREE_WORDS;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[writeAddr] <= {botIn, validBotPermutesIn};
        end
    end

    // Two register stages, matching the read latency seen by the top
    always_ff @(posedge clk) begin
        if (read) begin
            readStage <= mem[readAddr];
        end
        outStage <= readStage;
    end

    assign {botOut, validBotPermutesOut} = outStage;

    // A batch larger than 63 words would wrap the size field
    assert property (@(posedge clk) disable iff (rst)
        !(batchSizeReg == 6'd63 && write));

    // Reads only cover words of finished batches
    assert property (@(posedge clk) disable iff (rst)
        read |-> readAddr != writeAddr);

endmodule

//--- source/botPermuter.sv
`timescale 1ns/1ns
`include "botPermuter_defines.svh"

module botPermuter import botPermuterPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     startNewBurst,
    input  botT      botIn,
    input  permMaskT validBotPermutesIn,
    output logic     ready,
    output logic     permutedBotValid,
    output botT      permutedBot
);
    permStateT state;
    botT botReg;
    permMaskT maskReg;
    logic [2:0] selIdx;
    permMaskT selOneHot;
    logic lastEmit;

    // Output bit i reads input bit j, where the variable named first in the
    // ordering lands on position 4, the second on 5 and the third on 6
    function automatic botT shuffleBot(input botT src, input logic [2:0] sel);
        logic [8:0] positions;
        logic [6:0] outIdx;
        logic [6:0] srcIdx;
        botT res;
        // Source positions of the first, second and third named variable
        case (sel)
            3'd5: positions = {3'd4, 3'd5, 3'd6};
            3'd4: positions = {3'd4, 3'd6, 3'd5};
            3'd3: positions = {3'd5, 3'd4, 3'd6};
            3'd2: positions = {3'd5, 3'd6, 3'd4};
            3'd1: positions = {3'd6, 3'd4, 3'd5};
            default: positions = {3'd6, 3'd5, 3'd4};
        endcase
        for (int n = 0; n < `BOT_WIDTH; n++) begin
            outIdx = 7'(n);
            srcIdx = outIdx;
            srcIdx[positions[8:6]] = outIdx[4];
            srcIdx[positions[5:3]] = outIdx[5];
            srcIdx[positions[2:0]] = outIdx[6];
            res[n] = src[srcIdx];
        end
        return res;
    endfunction

    // Highest remaining mask bit is emitted first
    always_comb begin
        selIdx = 3'd0;
        for (int b = 0; b < `PERM_COUNT; b++) begin
            if (maskReg[b]) begin
                selIdx = 3'(b);
            end
        end
    end

    assign selOneHot = permMaskT'(1) << selIdx;
    assign lastEmit = (maskReg & (maskReg - 1'b1)) == '0;

    // Accepting in the last emit cycle keeps bursts back to back
    assign ready = (state == idle) || (state == emit && lastEmit);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else if (startNewBurst) begin
            state <= (validBotPermutesIn != '0) ? emit : idle;
        end else if (state == emit && lastEmit) begin
            state <= idle;
        end
    end

    always_ff @(posedge clk) begin
        if (startNewBurst) begin
            botReg <= botIn;
            maskReg <= validBotPermutesIn;
        end else if (state == emit) begin
            maskReg <= maskReg & ~selOneHot;
        end
    end

    always_ff @(posedge clk) begin
        if (state == emit) begin
            permutedBot <= shuffleBot(botReg, selIdx);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            permutedBotValid <= 1'b0;
        end else begin
            permutedBotValid <= (state == emit);
        end
    end

    // Upstream may only start a burst when the permuter can take it
    assert property (@(posedge clk) disable iff (rst) startNewBurst |-> ready);

endmodule

//--- source/botPermuterPkg.sv
`include "botPermuter_defines.svh"

package botPermuterPkg;

    // Bit index equals the 7-bit input assignment
    typedef logic [`BOT_WIDTH-1:0] botT;

    // Bit 5 down to bit 0: ABC, ACB, BAC, BCA, CAB, CBA
    typedef logic [`PERM_COUNT-1:0] permMaskT;

    // Stored words in one batch, at most 63
    typedef logic [5:0] batchSizeT;

    // Permuter burst FSM
    typedef enum logic {
        idle,
        emit
    } permStateT;

endpackage

//--- source/botPermuterWithFifo.sv
`timescale 1ns/1ns
`include "botPermuter_defines.svh"

module botPermuterWithFifo import botPermuterPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  botT      bot,
    input  logic     writeData,
    input  permMaskT validBotPermutes,
    input  logic     batchDone,
    output logic     slowDownInput,
    output botT      permutedBot,
    output logic     permutedBotValid,
    output logic     batchFinished,
    input  logic     requestSlowDown
);
    localparam int entryWidth = `BOT_WIDTH + `PERM_COUNT + 1;

    logic [`INPUT_FIFO_DEPTH_LOG2:0] fifoUsedw;
    logic fifoEmpty;
    logic fifoWrite;
    logic permuterReady;
    logic grabEntry;
    botT entryBot;
    permMaskT entryMask;
    logic entryDone;
    logic runTag;
    logic runFresh;
    logic [2:0] runCount;
    logic finishPre;

    function automatic logic [2:0] countBits(input permMaskT mask);
        logic [2:0] total;
        total = '0;
        for (int b = 0; b < `PERM_COUNT; b++) begin
            total = total + 3'(mask[b]);
        end
        return total;
    endfunction

    // Markers with an empty mask still travel to close their batch
    assign fifoWrite = writeData && ((validBotPermutes != '0) || batchDone);
    assign grabEntry = permuterReady && !fifoEmpty && !requestSlowDown;

    syncFifo #(
        .WIDTH(entryWidth),
        .DEPTH_LOG2(`INPUT_FIFO_DEPTH_LOG2)
    ) i_inputFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(fifoWrite),
        .dataIn({bot, validBotPermutes, batchDone}),
        .readEnable(grabEntry),
        .dataOut({entryBot, entryMask, entryDone}),
        .empty(fifoEmpty),
        .usedw(fifoUsedw)
    );

    botPermuter i_botPermuter (
        .clk(clk),
        .rst(rst),
        .startNewBurst(grabEntry),
        .botIn(entryBot),
        .validBotPermutesIn(entryMask),
        .ready(permuterReady),
        .permutedBotValid(permutedBotValid),
        .permutedBot(permutedBot)
    );

    // Mirror of the running burst. The count hits 1 in its last emit cycle,
    // one cycle ahead of the last output
    assign finishPre = runTag && ((runCount == 3'd1) || (runFresh && runCount == 3'd0));

    always_ff @(posedge clk) begin
        if (rst) begin
            runTag <= 1'b0;
            runFresh <= 1'b0;
            runCount <= '0;
            batchFinished <= 1'b0;
            slowDownInput <= 1'b0;
        end else begin
            runFresh <= grabEntry;
            if (grabEntry) begin
                runTag <= entryDone;
                runCount <= countBits(entryMask);
            end else if (runCount != '0) begin
                runCount <= runCount - 1'b1;
            end
            batchFinished <= finishPre;
            slowDownInput <= fifoUsedw > `SLOWDOWN_THRESHOLD;
        end
    end

endmodule

//--- source/botPermuterWithMultiFifo.sv
`timescale 1ns/1ns
`include "botPermuter_defines.svh"

module botPermuterWithMultiFifo import botPermuterPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  botT      bot,
    input  permMaskT validBotPermutes,
    input  logic     batchDone,
    output logic     readyForNextBatch,
    output botT      permutedBot,
    output logic     permutedBotValid,
    output logic     batchFinished,
    input  logic     requestSlowDown
);
    localparam int readLatency = `BATCH_READ_LATENCY;
    localparam int sizeFifoDepth = 1 << `SIZE_FIFO_DEPTH_LOG2;

    botT bufferBot;
    permMaskT bufferMask;
    batchSizeT batchSizeNow;
    logic bufferReady;
    batchSizeT sizeFifoData;
    logic sizeFifoEmpty;
    logic [`SIZE_FIFO_DEPTH_LOG2:0] sizeFifoUsedw;
    logic sizeFifoRead;
    logic sizeRoom;
    batchSizeT nextSize;
    logic nextSizeValid;
    batchSizeT remaining;
    logic grabNextSize;
    logic readStrobe;
    logic markerLoad;
    logic [readLatency-1:0] validPipe;
    logic [readLatency-1:0] lastPipe;
    logic [readLatency-1:0] markerPipe;
    logic slowDownInput;
    permMaskT permuterMask;

    batchBotBuffer i_batchBotBuffer (
        .clk(clk),
        .rst(rst),
        .botIn(bot),
        .validBotPermutesIn(validBotPermutes),
        .readyForNewBatch(bufferReady),
        .endBatch(batchDone),
        .batchSize(batchSizeNow),
        .read(readStrobe),
        .botOut(bufferBot),
        .validBotPermutesOut(bufferMask)
    );

    syncFifo #(
        .WIDTH($bits(batchSizeT)),
        .DEPTH_LOG2(`SIZE_FIFO_DEPTH_LOG2)
    ) i_sizeFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(batchDone),
        .dataIn(batchSizeNow),
        .readEnable(sizeFifoRead),
        .dataOut(sizeFifoData),
        .empty(sizeFifoEmpty),
        .usedw(sizeFifoUsedw)
    );

    // Also hold off new batches while the size FIFO runs short of room
    assign readyForNextBatch = bufferReady && sizeRoom;

    // Refill the next-size register whenever it is free or being consumed
    assign sizeFifoRead = !sizeFifoEmpty && (!nextSizeValid || grabNextSize);
    assign grabNextSize = (remaining == '0) && nextSizeValid;
    assign markerLoad = grabNextSize && (nextSize == '0);
    assign readStrobe = (remaining != '0) && !slowDownInput;

    always_ff @(posedge clk) begin
        if (sizeFifoRead) begin
            nextSize <= sizeFifoData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            nextSizeValid <= 1'b0;
            remaining <= '0;
            sizeRoom <= 1'b1;
            validPipe <= '0;
            lastPipe <= '0;
            markerPipe <= '0;
        end else begin
            if (sizeFifoRead) begin
                nextSizeValid <= 1'b1;
            end else if (grabNextSize) begin
                nextSizeValid <= 1'b0;
            end
            if (grabNextSize) begin
                remaining <= nextSize;
            end else if (readStrobe) begin
                remaining <= remaining - 1'b1;
            end
            sizeRoom <= int'(sizeFifoUsedw) < sizeFifoDepth - `SIZE_FIFO_MARGIN;
            // Follows the buffer read so flags meet their data
            validPipe <= {validPipe[readLatency-2:0], readStrobe || markerLoad};
            lastPipe <= {lastPipe[readLatency-2:0],
                         (readStrobe && remaining == 6'd1) || markerLoad};
            markerPipe <= {markerPipe[readLatency-2:0], markerLoad};
        end
    end

    // Empty batch has no word behind it
    assign permuterMask = markerPipe[readLatency-1] ? '0 : bufferMask;

    botPermuterWithFifo i_botPermuterWithFifo (
        .clk(clk),
        .rst(rst),
        .bot(bufferBot),
        .writeData(validPipe[readLatency-1]),
        .validBotPermutes(permuterMask),
        .batchDone(lastPipe[readLatency-1]),
        .slowDownInput(slowDownInput),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchFinished(batchFinished),
        .requestSlowDown(requestSlowDown)
    );

endmodule

//--- source/botPermuter_defines.svh
`ifndef BOT_PERMUTER_DEFINES_SVH
`define BOT_PERMUTER_DEFINES_SVH

// Truth table of a 7-input function and its number of orderings
`define BOT_WIDTH 128
`define PERM_COUNT 6

// Batch word buffer, 512 words, data two cycles after the read strobe
`define BATCH_DEPTH_LOG2 9
`define BATCH_READ_LATENCY 2
// Free words needed before a new batch may start
`define READY_FREE_WORDS 64

// Input FIFO in front of the permuter
`define INPUT_FIFO_DEPTH_LOG2 5
`define SLOWDOWN_THRESHOLD 24

// Batch-size FIFO and the room kept free for sizes still coming
`define SIZE_FIFO_DEPTH_LOG2 5
`define SIZE_FIFO_MARGIN 4

`endif

//--- source/syncFifo.sv
`timescale 1ns/1ns

module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  writeEnable,
    input  logic [WIDTH-1:0]      dataIn,
    input  logic                  readEnable,
    output logic [WIDTH-1:0]      dataOut,
    output logic                  empty,
    output logic [DEPTH_LOG2:0]   usedw
);
    localparam int fifoDepth = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0] mem [fifoDepth];
    logic [DEPTH_LOG2-1:0] writePtr;
    logic [DEPTH_LOG2-1:0] readPtr;

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            usedw <= '0;
        end else begin
            if (writeEnable) begin
                writePtr <= writePtr + 1'b1;
            end
            if (readEnable) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({writeEnable, readEnable})
                2'b10: usedw <= usedw + 1'b1;
                2'b01: usedw <= usedw - 1'b1;
                default: usedw <= usedw;
            endcase
        end
    end

    // Show-ahead: head entry is visible before it is read
    assign dataOut = mem[readPtr];
    assign empty = (usedw == '0);

    // Producers and consumers must respect the fill level
    assert property (@(posedge clk) disable iff (rst)
        writeEnable |-> usedw != (DEPTH_LOG2 + 1)'(fifoDepth));

    assert property (@(posedge clk) disable iff (rst)
        readEnable |-> !empty);

endmodule
